/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing
TOP ?= bt_bridge_tb
FILE_LIST ?= files.f
OBJ_DIR ?= obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* design/bt_bridge.sv */
/*
	Sensor to Bluetooth bridge.
	Stream and command FIFOs share one UART transmitter; received bytes go to a response FIFO.
*/

module bt_bridge
	import bt_bridge_pkg::*;
#(
	parameter int NUM_STREAMS = 4,
	parameter int FIFO_DEPTH = 8
)
(
	input logic clock,
	input logic reset,
	input link_config_t link_config,
	input logic [NUM_STREAMS-1:0] stream_write,
	input stream_word_t [NUM_STREAMS-1:0] stream_data,
	output logic [NUM_STREAMS-1:0] stream_full,
	input logic send_enable,
	input logic want_at,
	input logic at_write,
	input uart_byte_t at_byte,
	input logic at_start,
	input logic rxd,
	output logic txd,
	input logic resp_read,
	output uart_byte_t resp_byte,
	output logic resp_empty,
	output link_state_t state
);

	localparam int SEL_W = $clog2(NUM_STREAMS);

	stream_word_t stream_head [NUM_STREAMS];
	logic [NUM_STREAMS-1:0] stream_empty;
	logic [NUM_STREAMS-1:0] stream_pop;
	logic [SEL_W-1:0] select;
	logic select_ready;
	logic pop;
	logic at_pop;
	logic at_empty;
	uart_byte_t at_head;
	stream_word_t head_word;
	logic source_empty;
	logic tx_start;
	uart_byte_t tx_byte;
	logic tx_done;
	logic rx_valid;
	uart_byte_t rx_byte;

	// Pop goes to the command FIFO in command mode, else to the selected stream
	assign at_pop = pop && want_at;
	assign head_word = stream_head[select];
	assign source_empty = want_at ? at_empty : stream_empty[select];

	for (genvar i = 0; i < NUM_STREAMS; i++)
	begin : g_stream
		assign stream_pop[i] = pop && !want_at && (select == SEL_W'(i));

		sync_fifo #(.entry_t(stream_word_t), .FIFO_DEPTH(FIFO_DEPTH)) stream_fifo_i (
			.clock(clock), .reset(reset),
			.write(stream_write[i]), .write_data(stream_data[i]),
			.read(stream_pop[i]), .read_data(stream_head[i]),
			.empty(stream_empty[i]), .full(stream_full[i])
		);
	end

	sync_fifo #(.entry_t(uart_byte_t), .FIFO_DEPTH(FIFO_DEPTH)) at_fifo_i (
		.clock(clock), .reset(reset),
		.write(at_write), .write_data(at_byte),
		.read(at_pop), .read_data(at_head),
		.empty(at_empty), .full()
	);

	// Full response FIFO drops incoming bytes
	sync_fifo #(.entry_t(uart_byte_t), .FIFO_DEPTH(FIFO_DEPTH)) resp_fifo_i (
		.clock(clock), .reset(reset),
		.write(rx_valid), .write_data(rx_byte),
		.read(resp_read), .read_data(resp_byte),
		.empty(resp_empty), .full()
	);

	stream_arbiter #(.NUM_STREAMS(NUM_STREAMS)) arbiter_i (
		.clock(clock), .reset(reset),
		.stream_empty(stream_empty), .want_at(want_at), .at_empty(at_empty),
		.served(pop), .select(select), .select_ready(select_ready)
	);

	link_controller #(.NUM_STREAMS(NUM_STREAMS)) controller_i (
		.clock(clock), .reset(reset), .link_config(link_config),
		.want_at(want_at), .at_start(at_start), .send_enable(send_enable),
		.select_ready(select_ready), .head_word(head_word), .head_at(at_head),
		.source_empty(source_empty), .pop(pop),
		.tx_start(tx_start), .tx_byte(tx_byte), .tx_done(tx_done), .state(state)
	);

	uart_tx tx_i (
		.clock(clock), .reset(reset), .link_config(link_config),
		.tx_start(tx_start), .tx_byte(tx_byte), .txd(txd), .tx_done(tx_done)
	);

	uart_rx rx_i (
		.clock(clock), .reset(reset), .link_config(link_config),
		.rxd(rxd), .rx_valid(rx_valid), .rx_byte(rx_byte)
	);

endmodule

/* design/bt_bridge_pkg.sv */
/*
	Bluetooth bridge shared types.
	Sensor words, serial bytes, link timing and the link controller states.
*/

package bt_bridge_pkg;

	// One sensor sample, sent low byte first
	typedef logic [15:0] stream_word_t;

	// One serial byte on the UART
	typedef logic [7:0] uart_byte_t;

	// Bit time and inter-byte gap, both in clock cycles
	typedef struct packed {
		logic [9:0] cycles_per_bit;
		logic [9:0] gap_cycles;
	} link_config_t;

	// Transmit FSM states
	typedef enum logic [3:0] {
		state_idle,
		state_wait_select,
		state_release,
		state_load,
		state_transmit,
		state_rest
	} link_state_t;

endpackage

/* design/link_controller.sv */
/*
	Link controller.
	Pops words or command bytes, feeds the UART one byte at a time and times the gap.
*/

module link_controller
	import bt_bridge_pkg::*;
#(
	parameter int NUM_STREAMS = 4
)
(
	input logic clock,
	input logic reset,
	input link_config_t link_config,
	input logic want_at,
	input logic at_start,
	input logic send_enable,
	input logic select_ready,
	input stream_word_t head_word,
	input uart_byte_t head_at,
	input logic source_empty,
	output logic pop,
	output logic tx_start,
	output uart_byte_t tx_byte,
	input logic tx_done,
	output link_state_t state
);

	localparam int ROUND_W = $clog2(NUM_STREAMS + 1);

	stream_word_t word_buf;
	logic high_byte;
	logic command_item;
	logic [9:0] gap_count;
	logic [ROUND_W-1:0] round_count;
	logic more_items;
	logic round_done;

	// Pop in the same cycle the arbiter's select is used
	assign pop = (state == state_release) && !source_empty;

	// Another item is waiting in the current mode
	assign more_items = select_ready && (command_item ? want_at : (send_enable && !want_at));

	// Back through idle after one full pass over the streams
	assign round_done = (round_count == ROUND_W'(NUM_STREAMS));

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= state_idle;
			tx_start <= 1'b0;
			high_byte <= 1'b0;
			command_item <= 1'b0;
			gap_count <= '0;
			round_count <= '0;
		end
		else
		begin
			tx_start <= 1'b0;
			case (state)
				state_idle:
				begin
					round_count <= '0;
					if (want_at)
					begin
						if (at_start)
							state <= state_wait_select;
					end
					else if (send_enable && select_ready)
						state <= state_wait_select;
				end

				state_wait_select:
				begin
					if (select_ready)
						state <= state_release;
					else
						state <= state_idle;
				end

				state_release:
				begin
					if (source_empty)
						state <= state_idle;
					else
					begin
						command_item <= want_at;
						high_byte <= 1'b0;
						if (!want_at)
							round_count <= round_count + 1'b1;
						state <= state_load;
					end
				end

				state_load:
				begin
					tx_start <= 1'b1;
					state <= state_transmit;
				end

				state_transmit:
				begin
					if (tx_done)
					begin
						gap_count <= '0;
						state <= state_rest;
					end
				end

				state_rest:
				begin
					if (gap_count >= link_config.gap_cycles)
					begin
						if (!command_item && !high_byte)
						begin
							high_byte <= 1'b1;
							state <= state_load;
						end
						else if (more_items && (command_item || !round_done))
							state <= state_wait_select;
						else
							state <= state_idle;
					end
					else
						gap_count <= gap_count + 10'd1;
				end

				default:
					state <= state_idle;
			endcase
		end
	end

	// Payload registers
	always_ff @(posedge clock)
	begin
		if (pop)
			word_buf <= want_at ? {8'h00, head_at} : head_word;
		if (state == state_load)
			tx_byte <= high_byte ? word_buf[15:8] : word_buf[7:0];
	end

endmodule

/* design/stream_arbiter.sv */
/*
	Stream arbiter.
	Round-robin choice among non-empty stream FIFOs; the command FIFO wins in command mode.
*/

module stream_arbiter #(
	parameter int NUM_STREAMS = 4
)
(
	input logic clock,
	input logic reset,
	input logic [NUM_STREAMS-1:0] stream_empty,
	input logic want_at,
	input logic at_empty,
	input logic served,
	output logic [$clog2(NUM_STREAMS)-1:0] select,
	output logic select_ready
);

	localparam int SEL_W = $clog2(NUM_STREAMS);

	logic [SEL_W-1:0] last_served;
	logic [SEL_W-1:0] next_pick;
	logic any_stream;

	assign any_stream = |(~stream_empty);

	// First non-empty index after the last one served
	always_comb
	begin
		int idx;
		next_pick = last_served;
		// Walk downwards so the nearest index is the one kept
		for (int k = NUM_STREAMS; k >= 1; k--)
		begin
			idx = (int'(last_served) + k) % NUM_STREAMS;
			if (!stream_empty[idx])
				next_pick = SEL_W'(idx);
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			// Index 0 comes first after reset
			last_served <= SEL_W'(NUM_STREAMS - 1);
			select <= '0;
			select_ready <= 1'b0;
		end
		else
		begin
			if (served && !want_at)
				last_served <= select;
			select <= next_pick;
			select_ready <= want_at ? !at_empty : any_stream;
		end
	end

endmodule

/* design/sync_fifo.sv */
/*
	Single-clock FIFO.
	Circular buffer that serves stream words as well as command and response bytes.
*/

module sync_fifo #(
	parameter type entry_t = logic [7:0],
	parameter int FIFO_DEPTH = 8
)
(
	input logic clock,
	input logic reset,
	input logic write,
	input entry_t write_data,
	input logic read,
	output entry_t read_data,
	output logic empty,
	output logic full
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int COUNT_W = $clog2(FIFO_DEPTH + 1);

	entry_t storage [FIFO_DEPTH];
	logic [PTR_W-1:0] write_ptr;
	logic [PTR_W-1:0] read_ptr;
	logic [COUNT_W-1:0] count;
	logic do_write;
	logic do_read;

	// Drop writes when full, ignore reads when empty
	assign do_write = write && !full;
	assign do_read = read && !empty;

	assign empty = (count == '0);
	assign full = (count == COUNT_W'(FIFO_DEPTH));
	assign read_data = storage[read_ptr];

	function automatic logic [PTR_W-1:0] advance(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			write_ptr <= '0;
			read_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_write)
				write_ptr <= advance(write_ptr);
			if (do_read)
				read_ptr <= advance(read_ptr);
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (do_write)
			storage[write_ptr] <= write_data;
	end

endmodule

/* design/uart_rx.sv */
/*
	UART receiver.
	Samples each bit mid-way and flags a byte when the stop bit is good.
*/

module uart_rx
	import bt_bridge_pkg::*;
(
	input logic clock,
	input logic reset,
	input link_config_t link_config,
	input logic rxd,
	output logic rx_valid,
	output uart_byte_t rx_byte
);

	logic rxd_meta;
	logic rxd_sync;
	logic rxd_prev;
	logic busy;
	logic [3:0] bit_index;
	logic [9:0] bit_timer;
	logic [9:0] sample_point;
	logic sample_now;

	// Half a bit for the start bit, a full bit after that
	assign sample_point = (bit_index == 4'd0) ? (link_config.cycles_per_bit >> 1) - 10'd1
		: link_config.cycles_per_bit - 10'd1;
	assign sample_now = busy && (bit_timer == sample_point);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
			busy <= 1'b0;
			bit_index <= '0;
			bit_timer <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
			rx_valid <= 1'b0;
			if (!busy)
			begin
				// Falling edge of a start bit
				if (rxd_prev && !rxd_sync)
				begin
					busy <= 1'b1;
					bit_index <= '0;
					bit_timer <= '0;
				end
			end
			else if (sample_now)
			begin
				bit_timer <= '0;
				bit_index <= bit_index + 4'd1;
				if (bit_index == 4'd0 && rxd_sync)
					busy <= 1'b0;
				else if (bit_index == 4'd9)
				begin
					// Bad stop bit drops the frame
					busy <= 1'b0;
					rx_valid <= rxd_sync;
				end
			end
			else
				bit_timer <= bit_timer + 10'd1;
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clock)
	begin
		if (sample_now && bit_index >= 4'd1 && bit_index <= 4'd8)
			rx_byte <= {rxd_sync, rx_byte[7:1]};
	end

endmodule

/* design/uart_tx.sv */
/*
	UART transmitter.
	Sends one 8N1 frame per start strobe and pulses done after the stop bit.
*/

module uart_tx
	import bt_bridge_pkg::*;
(
	input logic clock,
	input logic reset,
	input link_config_t link_config,
	input logic tx_start,
	input uart_byte_t tx_byte,
	output logic txd,
	output logic tx_done
);

	// Stop, data and start bits; the line reads bit 0
	logic [9:0] frame;
	logic busy;
	logic [3:0] bit_index;
	logic [9:0] bit_timer;

	assign txd = frame[0];

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			// All ones keeps the line idle high
			frame <= '1;
			busy <= 1'b0;
			bit_index <= '0;
			bit_timer <= '0;
			tx_done <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			if (!busy)
			begin
				if (tx_start)
				begin
					frame <= {1'b1, tx_byte, 1'b0};
					busy <= 1'b1;
					bit_index <= '0;
					bit_timer <= '0;
				end
			end
			else if (bit_timer == link_config.cycles_per_bit - 10'd1)
			begin
				bit_timer <= '0;
				frame <= {1'b1, frame[9:1]};
				// Stop bit finished
				if (bit_index == 4'd9)
				begin
					busy <= 1'b0;
					tx_done <= 1'b1;
				end
				else
					bit_index <= bit_index + 4'd1;
			end
			else
				bit_timer <= bit_timer + 10'd1;
		end
	end

endmodule

/* files.f */
design/bt_bridge_pkg.sv
design/sync_fifo.sv
design/stream_arbiter.sv
design/uart_tx.sv
design/uart_rx.sv
design/link_controller.sv
design/bt_bridge.sv
testbench/bt_bridge_tb.sv

/* testbench/bt_bridge_cases.txt */
# Op then hex arguments: W stream word, B stream count first, C byte, S/M/E level, A at_start,
# H rxd byte, R resp byte, X txd byte, Y txd word, Z count first, F stream level, Q cycles
Q 14
# Round robin from index 0, stream 1 empty
B 0 2 0100
W 2 0200
B 3 2 0300
S 1
Y 0100
Y 0200
Y 0300
Y 0101
Y 0301
S 0
# One stream keeps write order
W 1 1234
W 1 abcd
S 1
Y 1234
Y abcd
S 0
# Command mode holds stream data back
M 1
S 1
W 2 5a5a
C 41
C 54
C 0d
Q 3c
A
X 41
X 54
X 0d
Q 3c
M 0
Y 5a5a
S 0
# Host bytes into the response FIFO
H 52
H 4f
H 4b
R 52
R 4f
R 4b
E 1
# Overfill stream 0, last word dropped
B 0 9 0600
F 0 1
S 1
Z 8 0600
F 0 0
S 0
Q c8

/* testbench/bt_bridge_tb.sv */
/*
	Testbench for the sensor to Bluetooth bridge.
	Replays the case file, decodes txd into bytes and drives rxd with serial frames.
*/

module bt_bridge_tb
	import bt_bridge_pkg::*;
();

	localparam int NUM_STREAMS = 4;
	localparam int FIFO_DEPTH = 8;
	localparam int CLOCK_PERIOD = 40;
	localparam int DRIVE_DELAY = 5;
	localparam int BIT_CYCLES = 4;
	localparam int GAP_CYCLES = 3;
	localparam int CYCLES_PER_LINE = 2000;
	// Room for two whole words with their gaps
	localparam int DRAIN_CYCLES = 4 * (10 * BIT_CYCLES + GAP_CYCLES + 8);
	localparam string CASE_FILE = "testbench/bt_bridge_cases.txt";

	logic clock = 1'b0;
	logic reset;
	link_config_t link_config;
	logic [NUM_STREAMS-1:0] stream_write;
	stream_word_t [NUM_STREAMS-1:0] stream_data;
	logic [NUM_STREAMS-1:0] stream_full;
	logic send_enable;
	logic want_at;
	logic at_write;
	uart_byte_t at_byte;
	logic at_start;
	logic rxd;
	logic txd;
	logic resp_read;
	uart_byte_t resp_byte;
	logic resp_empty;
	link_state_t state;

	// Bytes decoded from txd, oldest first
	uart_byte_t serial_bytes [$];
	logic reset_done = 1'b0;
	int watchdog_cycles = 0;
	int case_fd;

	bt_bridge #(.NUM_STREAMS(NUM_STREAMS), .FIFO_DEPTH(FIFO_DEPTH)) dut_i (
		.clock(clock), .reset(reset), .link_config(link_config),
		.stream_write(stream_write), .stream_data(stream_data), .stream_full(stream_full),
		.send_enable(send_enable), .want_at(want_at),
		.at_write(at_write), .at_byte(at_byte), .at_start(at_start),
		.rxd(rxd), .txd(txd),
		.resp_read(resp_read), .resp_byte(resp_byte), .resp_empty(resp_empty),
		.state(state)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("[FAIL] time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			abort_run();
		end
	endtask

	// Inputs change a little after the rising edge
	task automatic step();
		@(posedge clock);
		#DRIVE_DELAY;
	endtask

	task automatic count_case_lines(output int lines);
		int fd_count;
		int ch;
		lines = 0;
		fd_count = $fopen(CASE_FILE, "r");
		if (fd_count == 0)
		begin
			$display("Could not open the case file %s", CASE_FILE);
			abort_run();
		end
		ch = $fgetc(fd_count);
		while (ch != -1)
		begin
			if (ch == 10)
				lines++;
			ch = $fgetc(fd_count);
		end
		$fclose(fd_count);
	endtask

	task automatic read_hex(output logic [31:0] value);
		int code;
		code = $fscanf(case_fd, " %h", value);
		if (code != 1)
		begin
			$display("A case line is missing an argument");
			abort_run();
		end
	endtask

	task automatic skip_line();
		int ch;
		ch = $fgetc(case_fd);
		while (ch != 10 && ch != -1)
			ch = $fgetc(case_fd);
	endtask

	task automatic write_word(input int sel, input stream_word_t word);
		stream_data[sel] = word;
		stream_write[sel] = 1'b1;
		step();
		stream_write = '0;
	endtask

	task automatic expect_byte(input uart_byte_t expected);
		uart_byte_t actual;
		while (serial_bytes.size() == 0)
			step();
		actual = serial_bytes.pop_front();
		check_value("txd byte", 32'(actual), 32'(expected));
	endtask

	// Low byte goes out first
	task automatic expect_word(input stream_word_t word);
		expect_byte(word[7:0]);
		expect_byte(word[15:8]);
	endtask

	// One 8N1 frame on rxd, LSB first
	task automatic send_serial(input uart_byte_t value);
		logic [9:0] frame;
		frame = {1'b1, value, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			rxd = frame[i];
			repeat (BIT_CYCLES) @(posedge clock);
			#DRIVE_DELAY;
		end
	endtask

	task automatic read_response(input uart_byte_t expected);
		while (resp_empty)
			step();
		check_value("resp_byte", 32'(resp_byte), 32'(expected));
		resp_read = 1'b1;
		step();
		resp_read = 1'b0;
	endtask

	task automatic run_op(input logic [7:0] op);
		logic [31:0] arg_a;
		logic [31:0] arg_b;
		logic [31:0] arg_c;
		case (op)
			"#": skip_line();
			"W":
			begin
				read_hex(arg_a);
				read_hex(arg_b);
				write_word(int'(arg_a), arg_b[15:0]);
			end
			"B":
			begin
				read_hex(arg_a);
				read_hex(arg_b);
				read_hex(arg_c);
				for (int i = 0; i < int'(arg_b); i++)
					write_word(int'(arg_a), arg_c[15:0] + 16'(i));
			end
			"C":
			begin
				read_hex(arg_a);
				at_byte = arg_a[7:0];
				at_write = 1'b1;
				step();
				at_write = 1'b0;
			end
			"S":
			begin
				read_hex(arg_a);
				send_enable = arg_a[0];
				step();
			end
			"M":
			begin
				read_hex(arg_a);
				want_at = arg_a[0];
				step();
			end
			"A":
			begin
				at_start = 1'b1;
				step();
				at_start = 1'b0;
			end
			"H":
			begin
				read_hex(arg_a);
				send_serial(arg_a[7:0]);
			end
			"R":
			begin
				read_hex(arg_a);
				read_response(arg_a[7:0]);
			end
			"E":
			begin
				read_hex(arg_a);
				check_value("resp_empty", 32'(resp_empty), arg_a);
			end
			"F":
			begin
				read_hex(arg_a);
				read_hex(arg_b);
				check_value($sformatf("stream_full[%0d]", arg_a),
					32'(stream_full[int'(arg_a)]), arg_b);
			end
			"X":
			begin
				read_hex(arg_a);
				expect_byte(arg_a[7:0]);
			end
			"Y":
			begin
				read_hex(arg_a);
				expect_word(arg_a[15:0]);
			end
			"Z":
			begin
				read_hex(arg_a);
				read_hex(arg_b);
				for (int i = 0; i < int'(arg_a); i++)
					expect_word(arg_b[15:0] + 16'(i));
			end
			"Q":
			begin
				// Nothing may leave on txd during the wait
				read_hex(arg_a);
				repeat (arg_a) step();
				check_value("pending txd bytes", 32'(serial_bytes.size()), 32'd0);
				check_value("txd", 32'(txd), 32'd1);
			end
			default:
			begin
				$display("Unknown operation '%c' in the case file", op);
				abort_run();
			end
		endcase
	endtask

	// Serial decoder, samples each bit near its middle on the falling clock
	initial
	begin
		uart_byte_t value;
		wait (reset_done);
		forever
		begin
			@(negedge txd);
			repeat (BIT_CYCLES / 2) @(negedge clock);
			check_value("txd start bit", 32'(txd), 32'd0);
			for (int i = 0; i < 8; i++)
			begin
				repeat (BIT_CYCLES) @(negedge clock);
				value[i] = txd;
			end
			repeat (BIT_CYCLES) @(negedge clock);
			check_value("txd stop bit", 32'(txd), 32'd1);
			serial_bytes.push_back(value);
		end
	end

	// Watchdog
	initial
	begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clock);
		$display("The run timed out after %0d cycles", watchdog_cycles);
		abort_run();
	end

	initial
	begin
		logic [7:0] op;
		int code;
		int lines;
		reset = 1'b1;
		link_config = '{cycles_per_bit: 10'(BIT_CYCLES), gap_cycles: 10'(GAP_CYCLES)};
		stream_write = '0;
		stream_data = '0;
		send_enable = 1'b0;
		want_at = 1'b0;
		at_write = 1'b0;
		at_byte = '0;
		at_start = 1'b0;
		rxd = 1'b1;
		resp_read = 1'b0;

		count_case_lines(lines);
		watchdog_cycles = (lines + 1) * CYCLES_PER_LINE;

		repeat (2) @(posedge clock);
		#DRIVE_DELAY;
		reset = 1'b0;
		reset_done = 1'b1;
		step();

		// Quiet state right after reset
		check_value("txd", 32'(txd), 32'd1);
		check_value("resp_empty", 32'(resp_empty), 32'd1);
		check_value("state", 32'(state), 32'(state_idle));
		check_value("stream_full", 32'(stream_full), 32'd0);

		case_fd = $fopen(CASE_FILE, "r");
		if (case_fd == 0)
		begin
			$display("Could not open the case file %s", CASE_FILE);
			abort_run();
		end
		code = $fscanf(case_fd, " %c", op);
		while (code == 1)
		begin
			run_op(op);
			code = $fscanf(case_fd, " %c", op);
		end
		$fclose(case_fd);

		// Any word still held in a stream FIFO would leave now
		want_at = 1'b0;
		send_enable = 1'b1;
		repeat (DRAIN_CYCLES) step();
		check_value("leftover txd bytes", 32'(serial_bytes.size()), 32'd0);
		check_value("txd", 32'(txd), 32'd1);

		$display("RESULT: PASS");
		$finish;
	end

endmodule
